//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --timescale 1ns/1ps --top-module convolveTb -f verilog.f \
	&& ./obj_dir/VconvolveTb | tee /dev/stderr | grep "All checks passed" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- tb/convolveInput.txt
# columns: x h y of the normal case, then x h y of the saturating case, 16-bit hex
# one line per sample index n from 0 to 39, y is the upper half of the shifted sum
1000 FFCE FFCE 7FFF 7FFF 7FFF
0000 FFD5 FFD5 7FFF 7FFF 7FFF
0800 FFDC FFC3 8001 7FFF 000F
0000 FFE3 FFCD 8001 7FFF 8000
0000 FFEA FFD8 7FFF 7FFF 000F
F000 FFF1 0014 7FFF 7FFF 7FFF
0000 FFF8 0018 8001 7FFF 000F
0000 FFFF 001B 8001 7FFF 8000
0000 0006 001F 7FFF 7FFF 000F
0000 000D 0022 7FFF 7FFF 7FFF
0000 0014 0026 8001 7FFF 000F
0000 001B 0029 8001 7FFF 8000
0000 0022 002D 7FFF 7FFF 000F
0000 0029 0030 7FFF 7FFF 7FFF
0000 0030 0034 8001 7FFF 000F
0000 0037 0037 8001 7FFF 8000
0000 003E 003B 7FFF 7FFF 000F
0000 0045 003E 7FFF 7FFF 7FFF
0000 004C 0042 8001 7FFF 000F
0000 0053 0045 8001 7FFF 8000
0000 005A 0049 7FFF 7FFF 000F
0000 0061 004C 7FFF 7FFF 7FFF
0000 0068 0050 8001 7FFF 000F
0000 006F 0053 8001 7FFF 8000
0000 0076 0057 7FFF 7FFF 000F
0000 007D 005A 7FFF 7FFF 7FFF
0000 0084 005E 8001 7FFF 000F
0000 008B 0061 8001 7FFF 8000
0000 0092 0065 7FFF 7FFF 000F
0000 0099 0068 7FFF 7FFF 7FFF
0000 00A0 006C 8001 7FFF 000F
0000 00A7 006F 8001 7FFF 8000
0000 00AE 0073 7FFF 7FFF 000F
0000 00B5 0076 7FFF 7FFF 7FFF
0000 00BC 007A 8001 7FFF 000F
0000 00C3 007D 8001 7FFF 8000
0000 00CA 0081 7FFF 7FFF 000F
0000 00D1 0084 7FFF 7FFF 7FFF
0000 00D8 0088 8001 7FFF 000F
0000 00DF 008B 8001 7FFF 8000

//--- tb/convolveTb.sv
module convolveTb;

	timeunit 1ns;
	timeprecision 1ps;

	// Memory map of the three vectors, 64-word aligned
	localparam logic [10:0] xBase = 11'h040;
	localparam logic [10:0] hBase = 11'h080;
	localparam logic [10:0] yBase = 11'h0C0;
	localparam int numSamples = 40;
	localparam int runTimeout = 5000;
	localparam int quietCycles = 3500;

	logic clk;
	logic reset;
	logic start;
	logic done;
	logic hostWrEn;
	logic [10:0] hostAddr;
	logic [31:0] hostWrData;
	logic [31:0] hostRdData;

	// Vectors from the data file, normal and saturating case
	logic [15:0] xNorm [0:numSamples-1];
	logic [15:0] hNorm [0:numSamples-1];
	logic [15:0] yNorm [0:numSamples-1];
	logic [15:0] xSat [0:numSamples-1];
	logic [15:0] hSat [0:numSamples-1];
	logic [15:0] ySat [0:numSamples-1];
	int valueErrors;
	int otherErrors;

	convolveTop convolveTop_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.done(done),
		.hostWrEn(hostWrEn),
		.hostAddr(hostAddr),
		.hostWrData(hostWrData),
		.hostRdData(hostRdData)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Host port helpers
	//////////////////////////////////////////////////////////////////////

	// Inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic writeWord(input logic [10:0] addr, input logic [31:0] data);
		hostWrEn = 1'b1;
		hostAddr = addr;
		hostWrData = data;
		step();
		hostWrEn = 1'b0;
	endtask

	// Read data shows up one cycle after the address
	task automatic readWord(input logic [10:0] addr, output logic [31:0] data);
		hostAddr = addr;
		step();
		data = hostRdData;
	endtask

	task automatic checkWord(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			valueErrors++;
			$display("[ERROR] %s expected %08h got %08h", name, expected, actual);
		end
	endtask

	task automatic readInputFile();
		int fd;
		int got;
		int k;
		string header;
		fd = $fopen("tb/convolveInput.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file tb/convolveInput.txt");
			otherErrors++;
			return;
		end
		// Two comment lines describe the columns
		got = $fgets(header, fd);
		got = $fgets(header, fd);
		for (k = 0; k < numSamples; k++)
		begin
			got = $fscanf(fd, "%h %h %h %h %h %h\n", xNorm[k], hNorm[k], yNorm[k],
				xSat[k], hSat[k], ySat[k]);
			if (got != 6)
			begin
				$display("Stimulus file line for sample %0d is malformed", k);
				otherErrors++;
			end
		end
		$fclose(fd);
	endtask

	task automatic loadVectors(input bit satCase);
		int k;
		for (k = 0; k < numSamples; k++)
		begin
			writeWord(xBase + 11'(k), {16'h0000, satCase ? xSat[k] : xNorm[k]});
			writeWord(hBase + 11'(k), {16'h0000, satCase ? hSat[k] : hNorm[k]});
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Run and result checks
	//////////////////////////////////////////////////////////////////////

	// Optional second start a few cycles into the run
	task automatic runConvolution(input bit extraStart);
		int cycles;
		int pulses;
		start = 1'b1;
		step();
		start = 1'b0;
		cycles = 0;
		pulses = 0;
		while (pulses == 0 && cycles < runTimeout)
		begin
			if (done)
				pulses++;
			start = extraStart && cycles == 4;
			step();
			cycles++;
		end
		start = 1'b0;
		if (pulses == 0)
		begin
			$display("Timed out waiting for done after %0d cycles", runTimeout);
			otherErrors++;
		end
		// No further done pulse may follow, whether from a restart or a long pulse
		pulses = 0;
		for (cycles = 0; cycles < quietCycles; cycles++)
		begin
			if (done)
				pulses++;
			step();
		end
		assert (pulses == 0)
		else
		begin
			otherErrors++;
			$display("Saw %0d extra done pulses after the run ended", pulses);
		end
	endtask

	task automatic checkOutputs(input bit satCase);
		int k;
		logic [31:0] word;
		for (k = 0; k < numSamples; k++)
		begin
			readWord(yBase + 11'(k), word);
			checkWord($sformatf("y[%0d]", k), {16'h0000, satCase ? ySat[k] : yNorm[k]}, word);
		end
	endtask

	// The engine must leave x and h untouched
	task automatic checkInputs(input bit satCase);
		int k;
		logic [31:0] word;
		for (k = 0; k < numSamples; k++)
		begin
			readWord(xBase + 11'(k), word);
			checkWord($sformatf("x[%0d]", k), {16'h0000, satCase ? xSat[k] : xNorm[k]}, word);
			readWord(hBase + 11'(k), word);
			checkWord($sformatf("h[%0d]", k), {16'h0000, satCase ? hSat[k] : hNorm[k]}, word);
		end
	endtask

	initial
	begin : mainSequence
		int k;
		reset = 1'b1;
		start = 1'b0;
		hostWrEn = 1'b0;
		hostAddr = '0;
		hostWrData = '0;
		valueErrors = 0;
		otherErrors = 0;
		readInputFile();
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		// Idle engine keeps done low
		for (k = 0; k < 20; k++)
		begin
			checkWord("done", 32'h0, {31'b0, done});
			step();
		end

		loadVectors(1'b0);
		runConvolution(1'b0);
		checkOutputs(1'b0);
		checkInputs(1'b0);

		loadVectors(1'b1);
		runConvolution(1'b1);
		checkOutputs(1'b1);
		checkInputs(1'b1);

		$display("Value errors %0d, other errors %0d", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- verilog.f
verilog/basicOpsPkg.sv
verilog/convMemPkg.sv
verilog/convolveIfs.sv
verilog/scratchMem.sv
verilog/lMac.sv
verilog/lShl.sv
verilog/convolve.sv
verilog/convolveTop.sv
tb/convolveTb.sv

//--- verilog/basicOpsPkg.sv
package basicOpsPkg;

	//////////////////////////////////////////////////////////////////////
	// G.729 fixed-point word sizes
	//////////////////////////////////////////////////////////////////////

	// Word16 and Word32
	localparam int wordWidth = 16;
	localparam int longWidth = 32;

	// Most negative Word16, the one product that overflows L_mult
	localparam logic [wordWidth-1:0] minWord = 16'h8000;

	// Word32 saturation limits
	localparam logic [longWidth-1:0] maxLong = 32'h7FFF_FFFF;
	localparam logic [longWidth-1:0] minLong = 32'h8000_0000;

	//////////////////////////////////////////////////////////////////////
	// Convolution result shift
	//////////////////////////////////////////////////////////////////////

	localparam int shiftCountWidth = 2;
	localparam logic [shiftCountWidth-1:0] convShift = 2'd3;

endpackage

//--- verilog/convMemPkg.sv
package convMemPkg;

	//////////////////////////////////////////////////////////////////////
	// Scratch memory map
	//////////////////////////////////////////////////////////////////////

	localparam int addrWidth = 11;
	localparam int idxWidth = 6;

	// Regions are 64-word aligned so the index fills the low bits
	localparam logic [addrWidth-1:0] inputBase = 11'h040;
	localparam logic [addrWidth-1:0] impulseBase = 11'h080;
	localparam logic [addrWidth-1:0] outputBase = 11'h0C0;

	// Samples per vector
	localparam logic [idxWidth-1:0] vecLen = 6'd40;

	// One memory word, either whole or as two Word16 halves
	typedef union packed {
		logic [basicOpsPkg::longWidth-1:0] full;
		struct packed {
			logic [basicOpsPkg::wordWidth-1:0] hi;
			logic [basicOpsPkg::wordWidth-1:0] lo;
		} halves;
	} memWord;

	//////////////////////////////////////////////////////////////////////
	// Engine FSM state codes
	//////////////////////////////////////////////////////////////////////

	localparam int stateWidth = 3;
	localparam logic [stateWidth-1:0] stIdle = 3'd0;
	localparam logic [stateWidth-1:0] stCheckN = 3'd1;
	localparam logic [stateWidth-1:0] stCheckI = 3'd2;
	localparam logic [stateWidth-1:0] stReadH = 3'd3;
	localparam logic [stateWidth-1:0] stMac = 3'd4;
	localparam logic [stateWidth-1:0] stShlReady = 3'd5;
	localparam logic [stateWidth-1:0] stShlWait = 3'd6;

endpackage

//--- verilog/convolve.sv
module convolve (
	input logic clk,
	input logic reset,
	input logic start,
	output logic done,
	memBus.engine mem,
	macBus.engine mac,
	shlBus.engine shl
);

	logic [convMemPkg::stateWidth-1:0] state;
	logic [convMemPkg::stateWidth-1:0] nextState;
	logic [convMemPkg::idxWidth-1:0] n;
	logic [convMemPkg::idxWidth-1:0] i;
	logic [basicOpsPkg::longWidth-1:0] accum;
	logic [basicOpsPkg::wordWidth-1:0] xReg;

	// Region base with the sample index in the low bits
	function automatic logic [convMemPkg::addrWidth-1:0] regionAddr(
		input logic [convMemPkg::addrWidth-1:0] base,
		input logic [convMemPkg::idxWidth-1:0] idx
	);
		return {base[convMemPkg::addrWidth-1:convMemPkg::idxWidth], idx};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Next state and outputs
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		done = 1'b0;
		mem.addr = '0;
		mem.wrEn = 1'b0;
		mem.wrData = '0;
		mac.a = '0;
		mac.b = '0;
		mac.c = '0;
		shl.var1 = '0;
		shl.ready = 1'b0;

		case (state)
			convMemPkg::stIdle:
				if (start)
					nextState = convMemPkg::stCheckN;
			convMemPkg::stCheckN:
			begin
				if (n >= convMemPkg::vecLen)
				begin
					done = 1'b1;
					nextState = convMemPkg::stIdle;
				end
				else
					nextState = convMemPkg::stCheckI;
			end
			convMemPkg::stCheckI:
			begin
				// Inner loop over, i is cleared on this cycle
				if (i > n)
					nextState = convMemPkg::stShlReady;
				else
				begin
					mem.addr = regionAddr(convMemPkg::inputBase, i);
					nextState = convMemPkg::stReadH;
				end
			end
			convMemPkg::stReadH:
			begin
				mem.addr = regionAddr(convMemPkg::impulseBase, n - i);
				nextState = convMemPkg::stMac;
			end
			convMemPkg::stMac:
			begin
				mac.a = xReg;
				mac.b = mem.rdData.halves.lo;
				mac.c = accum;
				nextState = convMemPkg::stCheckI;
			end
			convMemPkg::stShlReady:
			begin
				shl.var1 = accum;
				shl.ready = 1'b1;
				nextState = convMemPkg::stShlWait;
			end
			convMemPkg::stShlWait:
			begin
				if (shl.done)
				begin
					// Upper half of the shifted sum, zero extended
					mem.addr = regionAddr(convMemPkg::outputBase, n);
					mem.wrEn = 1'b1;
					mem.wrData.halves.hi = '0;
					mem.wrData.halves.lo = shl.result[basicOpsPkg::longWidth-1 -: basicOpsPkg::wordWidth];
					nextState = convMemPkg::stCheckN;
				end
			end
			default:
				nextState = convMemPkg::stIdle;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// State and loop indices
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= convMemPkg::stIdle;
			n <= '0;
			i <= '0;
		end
		else
		begin
			state <= nextState;
			case (state)
				convMemPkg::stIdle:
				begin
					n <= '0;
					i <= '0;
				end
				convMemPkg::stCheckI:
					if (i > n)
						i <= '0;
				convMemPkg::stMac:
					i <= i + 1'b1;
				convMemPkg::stShlWait:
					if (shl.done)
						n <= n + 1'b1;
				default:
					;
			endcase
		end
	end

	// Accumulator and latched x sample
	always_ff @(posedge clk)
	begin
		case (state)
			convMemPkg::stCheckN:
				accum <= '0;
			convMemPkg::stReadH:
				xReg <= mem.rdData.halves.lo;
			convMemPkg::stMac:
				accum <= mac.result;
			default:
				;
		endcase
	end

endmodule

//--- verilog/convolveIfs.sv
// Engine side of the scratch memory, read data lags the address by one cycle
interface memBus;
	logic [convMemPkg::addrWidth-1:0] addr;
	logic wrEn;
	convMemPkg::memWord wrData;
	convMemPkg::memWord rdData;

	modport engine(output addr, output wrEn, output wrData, input rdData);
	modport mem(input addr, input wrEn, input wrData, output rdData);
endinterface

// Combinational L_mac operands and result
interface macBus;
	logic [basicOpsPkg::wordWidth-1:0] a;
	logic [basicOpsPkg::wordWidth-1:0] b;
	logic [basicOpsPkg::longWidth-1:0] c;
	logic [basicOpsPkg::longWidth-1:0] result;

	modport engine(output a, output b, output c, input result);
	modport unit(input a, input b, input c, output result);
endinterface

// L_shl handshake, ready starts a shift and done flags the result
interface shlBus;
	logic [basicOpsPkg::longWidth-1:0] var1;
	logic ready;
	logic done;
	logic [basicOpsPkg::longWidth-1:0] result;

	modport engine(output var1, output ready, input done, input result);
	modport unit(input var1, input ready, output done, output result);
endinterface

//--- verilog/convolveTop.sv
module convolveTop (
	input logic clk,
	input logic reset,
	input logic start,
	output logic done,
	input logic hostWrEn,
	input logic [convMemPkg::addrWidth-1:0] hostAddr,
	input logic [basicOpsPkg::longWidth-1:0] hostWrData,
	output logic [basicOpsPkg::longWidth-1:0] hostRdData
);

	memBus engMem();
	macBus macPath();
	shlBus shlPath();

	// Scratch memory shared by the engine and the host
	scratchMem scratchMem_i (
		.clk(clk),
		.eng(engMem.mem),
		.hostWrEn(hostWrEn),
		.hostAddr(hostAddr),
		.hostWrData(hostWrData),
		.hostRdData(hostRdData)
	);

	convolve convolve_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.done(done),
		.mem(engMem.engine),
		.mac(macPath.engine),
		.shl(shlPath.engine)
	);

	// Arithmetic helpers
	lMac lMac_i (
		.mac(macPath.unit)
	);

	lShl lShl_i (
		.clk(clk),
		.reset(reset),
		.shl(shlPath.unit)
	);

endmodule

//--- verilog/lMac.sv
module lMac (
	macBus.unit mac
);

	logic [basicOpsPkg::longWidth-1:0] aWide;
	logic [basicOpsPkg::longWidth-1:0] bWide;
	logic [basicOpsPkg::longWidth-1:0] rawProduct;
	logic [basicOpsPkg::longWidth-1:0] product;
	logic [basicOpsPkg::longWidth:0] sum;

	// Sign extend both Word16 operands to full width
	assign aWide = {{(basicOpsPkg::longWidth-basicOpsPkg::wordWidth){mac.a[basicOpsPkg::wordWidth-1]}},
		mac.a};
	assign bWide = {{(basicOpsPkg::longWidth-basicOpsPkg::wordWidth){mac.b[basicOpsPkg::wordWidth-1]}},
		mac.b};

	// Low word of the two's complement product is exact here
	assign rawProduct = aWide * bWide;

	// L_mult, the doubled product
	always_comb
	begin
		if (mac.a == basicOpsPkg::minWord && mac.b == basicOpsPkg::minWord)
			product = basicOpsPkg::maxLong;
		else
			product = {rawProduct[basicOpsPkg::longWidth-2:0], 1'b0};
	end

	// L_add with one guard bit for overflow detection
	assign sum = {mac.c[basicOpsPkg::longWidth-1], mac.c}
		+ {product[basicOpsPkg::longWidth-1], product};

	always_comb
	begin
		if (sum[basicOpsPkg::longWidth] != sum[basicOpsPkg::longWidth-1])
			mac.result = sum[basicOpsPkg::longWidth] ? basicOpsPkg::minLong : basicOpsPkg::maxLong;
		else
			mac.result = sum[basicOpsPkg::longWidth-1:0];
	end

endmodule

//--- verilog/lShl.sv
module lShl (
	input logic clk,
	input logic reset,
	shlBus.unit shl
);

	logic [basicOpsPkg::longWidth-1:0] value;
	logic [basicOpsPkg::shiftCountWidth-1:0] stepsLeft;

	// One-bit saturating shift step
	// A saturated value feeds back to itself on later steps
	function automatic logic [basicOpsPkg::longWidth-1:0] shiftStep(
		input logic [basicOpsPkg::longWidth-1:0] v
	);
		if (v[basicOpsPkg::longWidth-1] != v[basicOpsPkg::longWidth-2])
			return v[basicOpsPkg::longWidth-1] ? basicOpsPkg::minLong : basicOpsPkg::maxLong;
		return {v[basicOpsPkg::longWidth-2:0], 1'b0};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Step counter and done strobe
	//////////////////////////////////////////////////////////////////////

	// The ready edge already performs the first step
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			stepsLeft <= '0;
			shl.done <= 1'b0;
		end
		else
		begin
			shl.done <= 1'b0;
			if (shl.ready)
				stepsLeft <= basicOpsPkg::convShift - 1'b1;
			else if (stepsLeft != '0)
			begin
				stepsLeft <= stepsLeft - 1'b1;
				shl.done <= (stepsLeft - 1'b1) == '0;
			end
		end
	end

	// Shift datapath
	always_ff @(posedge clk)
	begin
		if (shl.ready)
			value <= shiftStep(shl.var1);
		else if (stepsLeft != '0)
			value <= shiftStep(value);
	end

	assign shl.result = value;

endmodule

//--- verilog/scratchMem.sv
module scratchMem (
	input logic clk,
	memBus.mem eng,
	input logic hostWrEn,
	input logic [convMemPkg::addrWidth-1:0] hostAddr,
	input logic [basicOpsPkg::longWidth-1:0] hostWrData,
	output logic [basicOpsPkg::longWidth-1:0] hostRdData
);

	convMemPkg::memWord store [0:(1 << convMemPkg::addrWidth)-1];

	//////////////////////////////////////////////////////////////////////
	// Write ports
	//////////////////////////////////////////////////////////////////////

	// Host write comes last so it wins on an address clash
	always_ff @(posedge clk)
	begin
		if (eng.wrEn)
			store[eng.addr] <= eng.wrData;
		if (hostWrEn)
			store[hostAddr] <= hostWrData;
	end

	//////////////////////////////////////////////////////////////////////
	// Read ports, one cycle latency
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		eng.rdData <= store[eng.addr];
		hostRdData <= store[hostAddr].full;
	end

endmodule
